// ==== logic/audio_mixer.sv ====
`timescale 1ns/1ps

module audio_mixer import hal_pkg::*; (
	input  logic      FPGA_CLK2_50,
	input  logic      resetd,
	input  sample_t   audio_ls,
	input  sample_t   audio_rs,
	input  logic      audio_s,
	input  mix_mode_t audio_mix,
	output sample_t   audio_l,
	output sample_t   audio_r
);

	// Logical or arithmetic right shift
	function automatic sample_t shr(sample_t v, int unsigned n, logic arith);
		if (arith) begin
			return v >>> n;
		end
		return v >> n;
	endfunction

	// One output channel from its own and the opposite input
	function automatic sample_t mix_chan(sample_t own, sample_t other,
		mix_mode_t mode, logic arith);
		case (mode)
			2'd1:    return own - shr(own, 3, arith) + shr(other, 3, arith);
			2'd2:    return own - shr(own, 2, arith) + shr(other, 2, arith);
			2'd3:    return shr(own, 1, arith) + shr(other, 1, arith);
			default: return own;
		endcase
	endfunction

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_chan(audio_ls, audio_rs, audio_mix, audio_s);
			audio_r <= mix_chan(audio_rs, audio_ls, audio_mix, audio_s);
		end
	end

endmodule

// ==== logic/front_panel.sv ====
`timescale 1ns/1ps

module front_panel import hal_pkg::*; #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	input  logic [1:0] key_n,
	output logic       btn_user,
	output logic       btn_osd,
	input  logic       led_user,
	input  logic [1:0] led_power,
	input  logic [1:0] led_disk,
	input  led_byte_t  led_overtake,
	input  led_byte_t  led_state,
	output logic       led_user_pin,
	output logic       led_hdd_pin,
	output logic       led_power_pin,
	output led_byte_t  led
);

	localparam int DIV_W = $clog2(DEBOUNCE_DIV + 2);

	// ======================================================================
	// Button debounce
	// ======================================================================

	// Bit 0 user, bit 1 OSD
	wire [1:0] press = {~(btn_osd_n & key_n[0]), ~(btn_user_n & key_n[1])};
	wire [1:0] btn_q;

	for (genvar i = 0; i < 2; i++) begin : g_btn
		logic [DIV_W-1:0]          div_cnt;
		logic [DEBOUNCE_DEPTH-1:0] hist;
		logic                      pressed;

		always_ff @(posedge FPGA_CLK2_50) begin
			if (resetd) begin
				div_cnt <= '0;
				hist    <= '0;
				pressed <= 1'b0;
			end else begin
				if (div_cnt == DIV_W'(DEBOUNCE_DIV)) begin
					div_cnt <= '0;
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end

				if (div_cnt == '0) begin
					hist <= {hist[DEBOUNCE_DEPTH-2:0], press[i]};
					// Full history of one level decides
					if (&hist) begin
						pressed <= 1'b1;
					end else if (hist == '0) begin
						pressed <= 1'b0;
					end
				end
			end
		end

		assign btn_q[i] = pressed;
	end

	assign btn_user = btn_q[0];
	assign btn_osd  = btn_q[1];

	// ======================================================================
	// LED drive
	// ======================================================================

	// A one leaves the pin floating
	wire power_off = led_power[1] ? ~led_power[0] : 1'b0;
	wire disk_off  = ~led_disk[0];
	wire user_off  = ~led_user;

	// Open drain board LEDs
	assign led_power_pin = power_off ? 1'bz : 1'b0;
	assign led_hdd_pin   = disk_off  ? 1'bz : 1'b0;
	assign led_user_pin  = user_off  ? 1'bz : 1'b0;

	// Host override per bit
	assign led = (led_overtake & led_state) |
		(~led_overtake & {3'b000, ~power_off, 1'b0, ~disk_off, 1'b0, ~user_off});

endmodule

// ==== logic/hal_pkg.sv ====
package hal_pkg;

	// ======================================================================
	// Widths with a meaning
	// ======================================================================

	// Host port data word
	typedef logic [15:0] host_word_t;
	typedef logic [7:0]  host_cmd_t;

	// Main board LED mask
	typedef logic [7:0] led_byte_t;

	// Audio sample from the core
	typedef logic signed [15:0] sample_t;

	// Cross-mix amount
	// 0 none, 1 one eighth, 2 one quarter, 3 half
	typedef logic [1:0] mix_mode_t;

	// Pixel with red in the top byte
	typedef logic [23:0] rgb_t;
	typedef logic [5:0]  vga_chan_t;

	// Host reset request code
	typedef logic [1:0] rst_code_t;

	// Command decoder states
	typedef enum logic [0:0] {
		ST_WAIT_CMD,
		ST_ARGS
	} cmd_state_t;

	// ======================================================================
	// Host commands and fields
	// ======================================================================

	localparam host_cmd_t CMD_CONFIG    = 8'h01;
	localparam host_cmd_t CMD_LED       = 8'h25;
	localparam int        CFG_CSYNC_BIT = 3;

	// Samples needed for a stable button
	localparam int DEBOUNCE_DEPTH = 8;

endpackage

// ==== logic/hal_top.sv ====
`timescale 1ns/1ps

module hal_top import hal_pkg::*; #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,

	// Host command port
	input  host_word_t io_din,
	input  logic       io_clk,
	input  logic       io_uio,
	output logic       io_ack,

	// Core reset
	input  rst_code_t  rst_code,
	output logic       core_reset,

	// Buttons and LEDs
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	input  logic [1:0] key_n,
	output logic       btn_user,
	output logic       btn_osd,
	input  logic       led_user,
	input  logic [1:0] led_power,
	input  logic [1:0] led_disk,
	output logic       led_user_pin,
	output logic       led_hdd_pin,
	output logic       led_power_pin,
	output led_byte_t  led,

	// Audio
	input  sample_t    audio_ls,
	input  sample_t    audio_rs,
	input  logic       audio_s,
	input  mix_mode_t  audio_mix,
	output sample_t    audio_l,
	output sample_t    audio_r,

	// Video
	input  rgb_t       core_rgb,
	input  logic       core_hs,
	input  logic       core_vs,
	input  logic       core_de,
	input  logic       vga_en,
	output vga_chan_t  vga_r,
	output vga_chan_t  vga_g,
	output vga_chan_t  vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic      cfg_got;
	logic      csync;
	led_byte_t led_overtake;
	led_byte_t led_state;

	host_cmd_decoder u_host_cmd_decoder (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.io_din       (io_din),
		.io_clk       (io_clk),
		.io_uio       (io_uio),
		.io_ack       (io_ack),
		.cfg_got      (cfg_got),
		.csync        (csync),
		.led_overtake (led_overtake),
		.led_state    (led_state)
	);

	reset_control u_reset_control (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.rst_code     (rst_code),
		.cfg_got      (cfg_got),
		.core_reset   (core_reset)
	);

	front_panel #(
		.DEBOUNCE_DIV (DEBOUNCE_DIV)
	) u_front_panel (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.btn_user_n    (btn_user_n),
		.btn_osd_n     (btn_osd_n),
		.key_n         (key_n),
		.btn_user      (btn_user),
		.btn_osd       (btn_osd),
		.led_user      (led_user),
		.led_power     (led_power),
		.led_disk      (led_disk),
		.led_overtake  (led_overtake),
		.led_state     (led_state),
		.led_user_pin  (led_user_pin),
		.led_hdd_pin   (led_hdd_pin),
		.led_power_pin (led_power_pin),
		.led           (led)
	);

	audio_mixer u_audio_mixer (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.audio_ls     (audio_ls),
		.audio_rs     (audio_rs),
		.audio_s      (audio_s),
		.audio_mix    (audio_mix),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	vga_output u_vga_output (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.core_rgb     (core_rgb),
		.core_hs      (core_hs),
		.core_vs      (core_vs),
		.core_de      (core_de),
		.csync        (csync),
		.vga_en       (vga_en),
		.vga_r        (vga_r),
		.vga_g        (vga_g),
		.vga_b        (vga_b),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs)
	);

endmodule

// ==== logic/host_cmd_decoder.sv ====
`timescale 1ns/1ps

module host_cmd_decoder import hal_pkg::*; (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  host_word_t io_din,
	input  logic       io_clk,
	input  logic       io_uio,
	output logic       io_ack,
	output logic       cfg_got,
	output logic       csync,
	output led_byte_t  led_overtake,
	output led_byte_t  led_state
);

	// ======================================================================
	// Input synchronisers
	// ======================================================================

	// Transfer clock chain
	// stages 0 and 1 synchronise, stage 2 finds the edge, stage 3 is the ack
	logic [3:0] clk_pipe;
	logic [1:0] uio_sync;
	host_word_t din_s1;
	host_word_t din_s2;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			clk_pipe <= '0;
			uio_sync <= '0;
		end else begin
			clk_pipe <= {clk_pipe[2:0], io_clk};
			uio_sync <= {uio_sync[0], io_uio};
		end
	end

	// Data has no reset
	always_ff @(posedge FPGA_CLK2_50) begin
		din_s1 <= io_din;
		din_s2 <= din_s1;
	end

	assign io_ack = clk_pipe[3];

	// Registered transfer strobe
	logic xfer_stb;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			xfer_stb <= 1'b0;
		end else begin
			xfer_stb <= clk_pipe[2] & ~clk_pipe[3];
		end
	end

	// ======================================================================
	// Command FSM
	// ======================================================================

	cmd_state_t state;
	host_cmd_t  cmd;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			state        <= ST_WAIT_CMD;
			cfg_got      <= 1'b0;
			csync        <= 1'b0;
			led_overtake <= '0;
			led_state    <= '0;
		end else if (!uio_sync[1]) begin
			// Frame closed by the host
			state <= ST_WAIT_CMD;
		end else if (xfer_stb) begin
			case (state)
				ST_WAIT_CMD: begin
					state <= ST_ARGS;
				end
				ST_ARGS: begin
					case (cmd)
						CMD_CONFIG: begin
							csync   <= din_s2[CFG_CSYNC_BIT];
							cfg_got <= 1'b1;
						end
						CMD_LED: begin
							led_overtake <= din_s2[15:8];
							led_state    <= din_s2[7:0];
						end
						default: begin
							// Unknown command, argument dropped
						end
					endcase
				end
				default: begin
					state <= ST_WAIT_CMD;
				end
			endcase
		end
	end

	// Command byte from the first word of a frame
	always_ff @(posedge FPGA_CLK2_50) begin
		if (uio_sync[1] && xfer_stb && state == ST_WAIT_CMD) begin
			cmd <= din_s2[7:0];
		end
	end

endmodule

// ==== logic/reset_control.sv ====
`timescale 1ns/1ps

module reset_control import hal_pkg::*; (
	input  logic      FPGA_CLK2_50,
	input  logic      resetd,
	input  rst_code_t rst_code,
	input  logic      cfg_got,
	output logic      core_reset
);

	rst_code_t code_s1;
	rst_code_t code_s2;
	rst_code_t code_prev;
	logic      reset_req;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			code_s1    <= '0;
			code_s2    <= '0;
			code_prev  <= '0;
			reset_req  <= 1'b1;
			core_reset <= 1'b1;
		end else begin
			code_s1   <= rst_code;
			code_s2   <= code_s1;
			code_prev <= code_s2;

			// Release only on the sequence 0 then 2
			if (code_s2 == 2'd1) begin
				reset_req <= 1'b1;
			end else if (code_s2 == 2'd2 && code_prev == 2'd0) begin
				reset_req <= 1'b0;
			end

			// Core stays in reset until configured
			core_reset <= reset_req | ~cfg_got;
		end
	end

endmodule

// ==== logic/sync_polarity_fix.sv ====
`timescale 1ns/1ps

module sync_polarity_fix import hal_pkg::*; (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);

	// Wide enough for a full frame at the board clock
	localparam int CNT_W = 20;

	logic [1:0]       sync_d;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			sync_d   <= '0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			sync_d <= {sync_d[0], sync_in};

			// Phase length captured at each edge
			if (sync_d[0] && !sync_d[1]) low_len <= cnt;
			if (!sync_d[0] && sync_d[1]) high_len <= cnt;

			if (sync_d[0] != sync_d[1]) begin
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end

			pol <= high_len > low_len;
		end
	end

	assign sync_out = sync_in ^ pol;

endmodule

// ==== logic/vga_output.sv ====
`timescale 1ns/1ps

module vga_output import hal_pkg::*; (
	input  logic      FPGA_CLK2_50,
	input  logic      resetd,
	input  rgb_t      core_rgb,
	input  logic      core_hs,
	input  logic      core_vs,
	input  logic      core_de,
	input  logic      csync,
	input  logic      vga_en,
	output vga_chan_t vga_r,
	output vga_chan_t vga_g,
	output vga_chan_t vga_b,
	output logic      vga_hs,
	output logic      vga_vs
);

	// Syncs with the short pulse high
	logic hs_fix;
	logic vs_fix;

	sync_polarity_fix u_hs_fix (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (core_hs),
		.sync_out     (hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (core_vs),
		.sync_out     (vs_fix)
	);

	// Black outside the active area
	rgb_t pix;
	assign pix = core_de ? core_rgb : '0;

	// Top six bits per colour, floating when the port is disabled
	assign vga_r = vga_en ? 'z : pix[23:18];
	assign vga_g = vga_en ? 'z : pix[15:10];
	assign vga_b = vga_en ? 'z : pix[7:2];

	// Composite sync rides on the horizontal line
	assign vga_vs = vga_en ? 1'bz : (csync ? 1'b1 : ~vs_fix);
	assign vga_hs = vga_en ? 1'bz : (csync ? ~(vs_fix ^ hs_fix) : ~hs_fix);

endmodule

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ======================================================================
// Result counting and typed compares
// ======================================================================

int checks_passed = 0;
int checks_failed = 0;

task automatic tally(input bit ok, input string what, input string got, input string exp);
	if (ok) begin
		checks_passed++;
	end else begin
		checks_failed++;
		$display("mismatch at %0t ns: %s got %s expected %s", $time, what, got, exp);
	end
endtask

task automatic report_failure(input string what);
	checks_failed++;
	$display("error at %0t ns: %s", $time, what);
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	tally(got === exp, what, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic check_led(input led_byte_t got, input led_byte_t exp, input string what);
	tally(got === exp, what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_sample(input sample_t got, input sample_t exp, input string what);
	tally(got === exp, what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_chan(input vga_chan_t got, input vga_chan_t exp, input string what);
	tally(got === exp, what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic finish_test(input string name, input int start);
	if (checks_failed == start) begin
		$display("%s: ok", name);
	end else begin
		$display("%s: %0d errors", name, checks_failed - start);
	end
endtask

// ======================================================================
// Drive helpers
// ======================================================================

// Ack must trail io_clk by four cycles
task automatic wait_ack(input logic level);
	int n = 0;
	while (io_ack !== level && n < ACK_LIMIT) begin
		@(negedge FPGA_CLK2_50);
		n++;
	end
	if (io_ack !== level) begin
		report_failure($sformatf("io_ack never followed io_clk to level %b", level));
	end else if (n != 4) begin
		report_failure($sformatf("io_ack took %0d cycles to follow io_clk, not 4", n));
	end
endtask

// One transfer, each io_clk level held eight cycles
task automatic host_xfer(input host_word_t word);
	@(negedge FPGA_CLK2_50);
	io_din = word;
	io_clk = 1'b1;
	wait_ack(1'b1);
	repeat (4) @(negedge FPGA_CLK2_50);
	io_clk = 1'b0;
	wait_ack(1'b0);
	repeat (4) @(negedge FPGA_CLK2_50);
endtask

// Command frame with a single argument word
task automatic send_cmd(input host_cmd_t cmd, input host_word_t arg);
	@(negedge FPGA_CLK2_50);
	io_uio = 1'b1;
	repeat (3) @(negedge FPGA_CLK2_50);
	host_xfer({8'h00, cmd});
	host_xfer(arg);
	io_uio = 1'b0;
	repeat (3) @(negedge FPGA_CLK2_50);
endtask

task automatic set_code(input rst_code_t code);
	@(negedge FPGA_CLK2_50);
	rst_code = code;
	repeat (6) @(negedge FPGA_CLK2_50);
endtask

task automatic hold_samples(input int periods);
	repeat (periods * SAMPLE_CYCLES) @(negedge FPGA_CLK2_50);
endtask

`endif

// ==== testbench/tb_hal_top.sv ====
`timescale 1ns/1ps

module tb_hal_top import hal_pkg::*; ();

	localparam int CLK_PERIOD    = 100;
	localparam int DIV           = 3;
	localparam int SAMPLE_CYCLES = DIV + 1;
	localparam int ACK_LIMIT     = 8;
	localparam int SYNC_PER      = 20;
	// Doubled cycle budgets of the six tests
	localparam int MAX_CYCLES    = 2 * (1000 + 500 + 2000 + 1500 + 3000 + 2000);

	logic       FPGA_CLK2_50 = 1'b0;
	logic       resetd;
	host_word_t io_din;
	logic       io_clk;
	logic       io_uio;
	logic       io_ack;
	rst_code_t  rst_code;
	logic       core_reset;
	logic       btn_user_n;
	logic       btn_osd_n;
	logic [1:0] key_n;
	logic       btn_user;
	logic       btn_osd;
	logic       led_user;
	logic [1:0] led_power;
	logic [1:0] led_disk;
	logic       led_user_pin;
	logic       led_hdd_pin;
	logic       led_power_pin;
	led_byte_t  led;
	sample_t    audio_ls;
	sample_t    audio_rs;
	logic       audio_s;
	mix_mode_t  audio_mix;
	sample_t    audio_l;
	sample_t    audio_r;
	rgb_t       core_rgb;
	logic       core_hs;
	logic       core_vs;
	logic       core_de;
	logic       vga_en;
	vga_chan_t  vga_r;
	vga_chan_t  vga_g;
	vga_chan_t  vga_b;
	logic       vga_hs;
	logic       vga_vs;
	int         cycles = 0;

	hal_top #(
		.DEBOUNCE_DIV (DIV)
	) u_dut (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.io_din        (io_din),
		.io_clk        (io_clk),
		.io_uio        (io_uio),
		.io_ack        (io_ack),
		.rst_code      (rst_code),
		.core_reset    (core_reset),
		.btn_user_n    (btn_user_n),
		.btn_osd_n     (btn_osd_n),
		.key_n         (key_n),
		.btn_user      (btn_user),
		.btn_osd       (btn_osd),
		.led_user      (led_user),
		.led_power     (led_power),
		.led_disk      (led_disk),
		.led_user_pin  (led_user_pin),
		.led_hdd_pin   (led_hdd_pin),
		.led_power_pin (led_power_pin),
		.led           (led),
		.audio_ls      (audio_ls),
		.audio_rs      (audio_rs),
		.audio_s       (audio_s),
		.audio_mix     (audio_mix),
		.audio_l       (audio_l),
		.audio_r       (audio_r),
		.core_rgb      (core_rgb),
		.core_hs       (core_hs),
		.core_vs       (core_vs),
		.core_de       (core_de),
		.vga_en        (vga_en),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs)
	);

	`include "tb_checks.svh"

	always #(CLK_PERIOD / 2) FPGA_CLK2_50 = ~FPGA_CLK2_50;

	always @(posedge FPGA_CLK2_50) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: test sequence still running after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ======================================================================
	// Reference rules
	// ======================================================================

	// Board LED activity with one bit per lit LED
	function automatic led_byte_t board_leds(logic user, logic [1:0] power, logic [1:0] disk);
		led_byte_t v;
		v = '0;
		v[0] = user;
		v[2] = disk[0];
		v[4] = !power[1] || power[0];
		return v;
	endfunction

	function automatic int shifted(sample_t v, int n, logic arith);
		if (arith) begin
			return int'(v) >>> n;
		end
		return int'({16'h0000, v}) >> n;
	endfunction

	// Cross mix wrapped to 16 bits
	function automatic sample_t mixed(sample_t own, sample_t other, mix_mode_t mode,
		logic arith);
		int acc;
		case (mode)
			2'd1: acc = int'(own) - shifted(own, 3, arith) + shifted(other, 3, arith);
			2'd2: acc = int'(own) - shifted(own, 2, arith) + shifted(other, 2, arith);
			2'd3: acc = shifted(own, 1, arith) + shifted(other, 1, arith);
			default: acc = int'(own);
		endcase
		return sample_t'(acc);
	endfunction

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic test_reset_config();
		int start;
		start = checks_failed;
		check_bit(core_reset, 1'b1, "core_reset after reset");
		check_bit(io_ack, 1'b0, "io_ack after reset");
		check_bit(btn_user, 1'b0, "btn_user after reset");
		check_sample(audio_l, '0, "audio_l after reset");
		check_sample(audio_r, '0, "audio_r after reset");
		// Request cleared but no configuration yet
		set_code(2'd0);
		set_code(2'd2);
		check_bit(core_reset, 1'b1, "core_reset before configuration");
		send_cmd(CMD_CONFIG, host_word_t'(1 << CFG_CSYNC_BIT));
		check_bit(core_reset, 1'b0, "core_reset after configuration");
		finish_test("reset and configuration", start);
	endtask

	task automatic test_reset_guard();
		int start;
		start = checks_failed;
		set_code(2'd1);
		check_bit(core_reset, 1'b1, "core_reset after code 1");
		set_code(2'd2);
		check_bit(core_reset, 1'b1, "core_reset after code 2 alone");
		set_code(2'd0);
		check_bit(core_reset, 1'b1, "core_reset after code 0");
		set_code(2'd2);
		check_bit(core_reset, 1'b0, "core_reset after code 0 then 2");
		finish_test("reset guard", start);
	endtask

	task automatic test_leds();
		int start;
		led_byte_t base;
		host_word_t word;
		start = checks_failed;
		for (int i = 0; i < 32; i++) begin
			@(negedge FPGA_CLK2_50);
			{led_user, led_power, led_disk} = 5'(i);
			#(CLK_PERIOD / 4);
			base = board_leds(led_user, led_power, led_disk);
			check_led(led, base, "led without override");
			check_bit(led_user_pin, base[0] ? 1'b0 : 1'bz, "led_user_pin");
			check_bit(led_hdd_pin, base[2] ? 1'b0 : 1'bz, "led_hdd_pin");
			check_bit(led_power_pin, base[4] ? 1'b0 : 1'bz, "led_power_pin");
		end
		for (int f = 0; f < 3; f++) begin
			word = host_word_t'($urandom());
			send_cmd(CMD_LED, word);
			for (int i = 0; i < 4; i++) begin
				@(negedge FPGA_CLK2_50);
				{led_user, led_power, led_disk} = 5'($urandom());
				#(CLK_PERIOD / 4);
				base = board_leds(led_user, led_power, led_disk);
				check_led(led, (word[15:8] & word[7:0]) | (~word[15:8] & base),
					"led with override");
			end
		end
		send_cmd(CMD_LED, '0);
		finish_test("led override", start);
	endtask

	task automatic test_buttons();
		int start;
		start = checks_failed;
		@(negedge FPGA_CLK2_50);
		btn_user_n = 1'b0;
		hold_samples(12);
		check_bit(btn_user, 1'b1, "btn_user after press");
		check_bit(btn_osd, 1'b0, "btn_osd while user pressed");
		// Short release glitch
		btn_user_n = 1'b1;
		hold_samples(4);
		btn_user_n = 1'b0;
		hold_samples(2);
		check_bit(btn_user, 1'b1, "btn_user after release glitch");
		btn_user_n = 1'b1;
		hold_samples(12);
		check_bit(btn_user, 1'b0, "btn_user after release");
		// Short press glitch
		btn_user_n = 1'b0;
		hold_samples(4);
		btn_user_n = 1'b1;
		hold_samples(2);
		check_bit(btn_user, 1'b0, "btn_user after press glitch");
		key_n[0] = 1'b0;
		hold_samples(12);
		check_bit(btn_osd, 1'b1, "btn_osd after key press");
		key_n[0] = 1'b1;
		hold_samples(12);
		check_bit(btn_osd, 1'b0, "btn_osd after key release");
		finish_test("buttons", start);
	endtask

	task automatic test_audio();
		int start;
		start = checks_failed;
		for (int m = 0; m < 8; m++) begin
			for (int k = 0; k < 40; k++) begin
				@(negedge FPGA_CLK2_50);
				audio_mix = mix_mode_t'(m);
				audio_s   = m[2];
				audio_ls  = sample_t'($urandom());
				audio_rs  = sample_t'($urandom());
				@(negedge FPGA_CLK2_50);
				check_sample(audio_l, mixed(audio_ls, audio_rs, audio_mix, audio_s), "audio_l");
				check_sample(audio_r, mixed(audio_rs, audio_ls, audio_mix, audio_s), "audio_r");
			end
		end
		finish_test("audio mix", start);
	endtask

	// Active low hsync, active high vsync, both short pulses
	task automatic sync_periods(input int periods, input logic csync_on, input logic check);
		int p;
		logic hs_pulse;
		logic vs_pulse;
		for (int k = 0; k < periods * SYNC_PER; k++) begin
			p = k % SYNC_PER;
			hs_pulse = p < 3;
			vs_pulse = p >= 10 && p < 14;
			@(negedge FPGA_CLK2_50);
			core_hs = ~hs_pulse;
			core_vs = vs_pulse;
			#(CLK_PERIOD / 4);
			if (check) begin
				check_bit(vga_hs, csync_on ? ~(hs_pulse ^ vs_pulse) : ~hs_pulse, "vga_hs");
				check_bit(vga_vs, csync_on ? 1'b1 : ~vs_pulse, "vga_vs");
			end
		end
	endtask

	task automatic test_vga();
		int start;
		start = checks_failed;
		send_cmd(CMD_CONFIG, '0);
		sync_periods(4, 1'b0, 1'b0);
		sync_periods(2, 1'b0, 1'b1);
		send_cmd(CMD_CONFIG, host_word_t'(1 << CFG_CSYNC_BIT));
		sync_periods(4, 1'b1, 1'b0);
		sync_periods(2, 1'b1, 1'b1);
		for (int i = 0; i < 8; i++) begin
			@(negedge FPGA_CLK2_50);
			core_rgb = rgb_t'($urandom());
			core_de  = i[0];
			#(CLK_PERIOD / 4);
			check_chan(vga_r, core_de ? vga_chan_t'(core_rgb[23:16] >> 2) : '0, "vga_r");
			check_chan(vga_g, core_de ? vga_chan_t'(core_rgb[15:8] >> 2) : '0, "vga_g");
			check_chan(vga_b, core_de ? vga_chan_t'(core_rgb[7:0] >> 2) : '0, "vga_b");
		end
		@(negedge FPGA_CLK2_50);
		vga_en = 1'b1;
		#(CLK_PERIOD / 4);
		check_chan(vga_r, {6{1'bz}}, "vga_r disabled");
		check_chan(vga_g, {6{1'bz}}, "vga_g disabled");
		check_chan(vga_b, {6{1'bz}}, "vga_b disabled");
		check_bit(vga_hs, 1'bz, "vga_hs disabled");
		check_bit(vga_vs, 1'bz, "vga_vs disabled");
		@(negedge FPGA_CLK2_50);
		vga_en = 1'b0;
		finish_test("vga output", start);
	endtask

	initial begin
		void'($urandom(30979));
		resetd     = 1'b1;
		io_din     = '0;
		io_clk     = 1'b0;
		io_uio     = 1'b0;
		rst_code   = '0;
		btn_user_n = 1'b1;
		btn_osd_n  = 1'b1;
		key_n      = 2'b11;
		led_user   = 1'b0;
		led_power  = '0;
		led_disk   = '0;
		audio_ls   = 16'h1234;
		audio_rs   = 16'h5678;
		audio_s    = 1'b0;
		audio_mix  = '0;
		core_rgb   = '0;
		core_hs    = 1'b1;
		core_vs    = 1'b0;
		core_de    = 1'b0;
		vga_en     = 1'b0;
		repeat (2) @(posedge FPGA_CLK2_50);
		@(negedge FPGA_CLK2_50);
		resetd = 1'b0;

		test_reset_config();
		test_reset_guard();
		test_leds();
		test_buttons();
		test_audio();
		test_vga();

		$display("checks passed %0d, failed %0d", checks_passed, checks_failed);
		if (checks_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+testbench
logic/hal_pkg.sv
logic/sync_polarity_fix.sv
logic/host_cmd_decoder.sv
logic/reset_control.sv
logic/front_panel.sv
logic/audio_mixer.sv
logic/vga_output.sv
logic/hal_top.sv
testbench/tb_hal_top.sv
